// File: common/mem_stage_macros.svh
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// ######################################
// Widths
// ######################################

`define MEM_DATA_W      32
`define MEM_RAM_ADDR_W  10                  // 1024 words

// ######################################
// Load/store select codes
// ######################################

`define LS_SEL_NONE     4'h0
`define LS_SB           4'h1
`define LS_SH           4'h2
`define LS_SW           4'h3
`define LS_LB           4'h4
`define LS_LBU          4'h5
`define LS_LH           4'h6
`define LS_LHU          4'h7
`define LS_LW           4'h8

`endif

// File: common/mem_stage_pkg.sv
`default_nettype none

`include "mem_stage_macros.svh"

package mem_stage_pkg;

    // ######################################
    // RAM data word views
    // ######################################

    // One RAM word, decoded per byte lane or per halfword lane
    typedef union packed {
        logic [`MEM_DATA_W-1:0]          word;
        logic [`MEM_DATA_W/8-1:0][7:0]   bytes;     // Lane 0 at bits 7:0
        logic [`MEM_DATA_W/16-1:0][15:0] halves;    // Lane 0 at bits 15:0
    } ram_word_u;

endpackage

`default_nettype wire

// File: common/data_ram_if.sv
`default_nettype none

`include "mem_stage_macros.svh"

// Load/store unit to data RAM port, fixed one-cycle read latency
interface data_ram_if;

    logic                       en;         // Access strobe
    logic [3:0]                 we;         // Byte write enables
    logic [`MEM_RAM_ADDR_W-1:0] addr;       // Word address
    logic [`MEM_DATA_W-1:0]     wdata;
    logic [`MEM_DATA_W-1:0]     rdata;      // Valid the cycle after en

    modport lsu_side (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport ram_side (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: common/ex_mem_if.sv
`default_nettype none

`include "mem_stage_macros.svh"

// Registered execute-to-memory fields
interface ex_mem_if;

    logic [`MEM_DATA_W-1:0] alu_res;
    logic                   ls_ena;
    logic [3:0]             ls_sel;
    logic                   w_reg_ena;
    logic [4:0]             w_reg_dst;
    logic                   wb_reg_sel;
    logic [1:0]             w_hilo_ena;     // {hi, lo}
    logic [`MEM_DATA_W-1:0] hi_res;
    logic [`MEM_DATA_W-1:0] lo_res;

    modport producer (
        output alu_res,
        output ls_ena,
        output ls_sel,
        output w_reg_ena,
        output w_reg_dst,
        output wb_reg_sel,
        output w_hilo_ena,
        output hi_res,
        output lo_res
    );

    modport consumer (
        input  alu_res,
        input  ls_ena,
        input  ls_sel,
        input  w_reg_ena,
        input  w_reg_dst,
        input  wb_reg_sel,
        input  w_hilo_ena,
        input  hi_res,
        input  lo_res
    );

endinterface

`default_nettype wire

// File: hdl/ex_mem_reg.sv
`default_nettype none

`include "mem_stage_macros.svh"

module ex_mem_reg (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   stall,

    input  wire [`MEM_DATA_W-1:0] ex_alu_res,
    input  wire                   ex_ls_ena,
    input  wire [3:0]             ex_ls_sel,
    input  wire                   ex_w_reg_ena,
    input  wire [4:0]             ex_w_reg_dst,
    input  wire                   ex_wb_reg_sel,
    input  wire [1:0]             ex_w_hilo_ena,
    input  wire [`MEM_DATA_W-1:0] ex_hi_res,
    input  wire [`MEM_DATA_W-1:0] ex_lo_res,

    ex_mem_if.producer            ex_mem
);

    // ######################################
    // Control fields
    // ######################################

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.ls_ena     <= 1'b0;
            ex_mem.ls_sel     <= `LS_SEL_NONE;
            ex_mem.w_reg_ena  <= 1'b0;          // No write-back after reset
            ex_mem.w_hilo_ena <= 2'b00;
        end else if (!stall) begin
            ex_mem.ls_ena     <= ex_ls_ena;
            ex_mem.ls_sel     <= ex_ls_sel;
            ex_mem.w_reg_ena  <= ex_w_reg_ena;
            ex_mem.w_hilo_ena <= ex_w_hilo_ena;
        end
    end

    // ######################################
    // Payload fields
    // ######################################

    always_ff @(posedge clk) begin
        if (!stall) begin                       // Hold while stalled
            ex_mem.alu_res    <= ex_alu_res;
            ex_mem.w_reg_dst  <= ex_w_reg_dst;
            ex_mem.wb_reg_sel <= ex_wb_reg_sel;
            ex_mem.hi_res     <= ex_hi_res;
            ex_mem.lo_res     <= ex_lo_res;
        end
    end

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
`default_nettype none

`include "mem_stage_macros.svh"

module data_ram (
    input  wire          clk,
    data_ram_if.ram_side ram
);

    localparam int DEPTH = 1 << `MEM_RAM_ADDR_W;
    localparam int LANES = `MEM_DATA_W / 8;

    logic [`MEM_DATA_W-1:0] mem [0:DEPTH-1];

    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (ram.en) begin
            for (int i = 0; i < LANES; i++) begin
                if (ram.we[i]) begin
                    mem[ram.addr][i*8 +: 8] <= ram.wdata[i*8 +: 8];
                end
            end
        end
    end

    // Read word registered on every access, old data on a write
    always_ff @(posedge clk) begin
        if (ram.en) begin
            ram.rdata <= mem[ram.addr];
        end
    end

endmodule

`default_nettype wire

// File: lsu/lsu.sv
`default_nettype none

`include "mem_stage_macros.svh"

module lsu (
    input  wire                    stall,

    // Execute stage request
    input  wire [`MEM_DATA_W-1:0]  ex_alu_res,
    input  wire [`MEM_DATA_W-1:0]  ex_rt_data,
    input  wire                    ex_ls_ena,
    input  wire [3:0]              ex_ls_sel,

    ex_mem_if.consumer             ex_mem,
    data_ram_if.lsu_side           ram,

    output logic [`MEM_DATA_W-1:0] mem_alu_res,
    output logic                   mem_w_reg_ena,
    output logic [4:0]             mem_w_reg_dst,
    output logic [`MEM_DATA_W-1:0] mem_r_data,
    output logic                   mem_wb_reg_sel,
    output logic [1:0]             mem_w_hilo_ena,
    output logic [`MEM_DATA_W-1:0] mem_hi_res,
    output logic [`MEM_DATA_W-1:0] mem_lo_res
);

    // ######################################
    // Store side
    // ######################################

    logic [3:0]                st_mask;
    logic [1:0]                st_off;
    mem_stage_pkg::ram_word_u  st_word;

    assign st_off = ex_alu_res[1:0];

    always_comb begin
        st_mask      = 4'b0000;
        st_word.word = '0;
        case (ex_ls_sel)
            `LS_SB: begin
                st_mask = 4'b0001;
                for (int i = 0; i < `MEM_DATA_W/8; i++) begin
                    st_word.bytes[i] = ex_rt_data[7:0];     // Byte in every lane
                end
            end
            `LS_SH: begin
                st_mask = 4'b0011;
                for (int i = 0; i < `MEM_DATA_W/16; i++) begin
                    st_word.halves[i] = ex_rt_data[15:0];
                end
            end
            `LS_SW: begin
                st_mask      = 4'b1111;
                st_word.word = ex_rt_data;
            end
            default: begin
                st_mask      = 4'b0000;                     // Loads write nothing
                st_word.word = '0;
            end
        endcase
    end

    assign ram.en    = ex_ls_ena & ~stall;                  // Request dropped while stalled
    assign ram.we    = st_mask << st_off;
    assign ram.addr  = ex_alu_res[`MEM_RAM_ADDR_W+1:2];
    assign ram.wdata = st_word.word;

    // ######################################
    // Load side
    // ######################################

    mem_stage_pkg::ram_word_u  ld_word;
    logic [1:0]                ld_off;
    logic [7:0]                ld_byte;
    logic [15:0]               ld_half;
    logic [`MEM_DATA_W-1:0]    ld_data;

    assign ld_word = ram.rdata;
    assign ld_off  = ex_mem.alu_res[1:0];                   // Registered byte offset
    assign ld_byte = ld_word.bytes[ld_off];
    assign ld_half = ld_word.halves[ld_off[1]];

    always_comb begin
        case (ex_mem.ls_sel)
            `LS_LB:  ld_data = {{24{ld_byte[7]}}, ld_byte};
            `LS_LBU: ld_data = {24'd0, ld_byte};
            `LS_LH:  ld_data = {{16{ld_half[15]}}, ld_half};
            `LS_LHU: ld_data = {16'd0, ld_half};
            `LS_LW:  ld_data = ld_word.word;
            default: ld_data = '0;                          // Stores and non-memory ops
        endcase
    end

    assign mem_r_data = ex_mem.ls_ena ? ld_data : '0;

    // Write-back fields
    assign mem_alu_res    = ex_mem.alu_res;
    assign mem_w_reg_ena  = ex_mem.w_reg_ena;
    assign mem_w_reg_dst  = ex_mem.w_reg_dst;
    assign mem_wb_reg_sel = ex_mem.wb_reg_sel;
    assign mem_w_hilo_ena = ex_mem.w_hilo_ena;
    assign mem_hi_res     = ex_mem.hi_res;
    assign mem_lo_res     = ex_mem.lo_res;

endmodule

`default_nettype wire

// File: hdl/mem_stage_top.sv
`default_nettype none

`include "mem_stage_macros.svh"

module mem_stage_top (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   stall,

    // Execute stage
    input  wire [`MEM_DATA_W-1:0] ex_alu_res,
    input  wire [`MEM_DATA_W-1:0] ex_rt_data,
    input  wire                   ex_ls_ena,
    input  wire [3:0]             ex_ls_sel,
    input  wire                   ex_w_reg_ena,
    input  wire [4:0]             ex_w_reg_dst,
    input  wire                   ex_wb_reg_sel,
    input  wire [1:0]             ex_w_hilo_ena,
    input  wire [`MEM_DATA_W-1:0] ex_hi_res,
    input  wire [`MEM_DATA_W-1:0] ex_lo_res,

    // Memory stage
    output wire [`MEM_DATA_W-1:0] mem_alu_res,
    output wire                   mem_w_reg_ena,
    output wire [4:0]             mem_w_reg_dst,
    output wire [`MEM_DATA_W-1:0] mem_r_data,
    output wire                   mem_wb_reg_sel,
    output wire [1:0]             mem_w_hilo_ena,
    output wire [`MEM_DATA_W-1:0] mem_hi_res,
    output wire [`MEM_DATA_W-1:0] mem_lo_res
);

    ex_mem_if   ex_mem ();
    data_ram_if ram_bus ();

    ex_mem_reg u_ex_mem_reg (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .ex_alu_res    (ex_alu_res),
        .ex_ls_ena     (ex_ls_ena),
        .ex_ls_sel     (ex_ls_sel),
        .ex_w_reg_ena  (ex_w_reg_ena),
        .ex_w_reg_dst  (ex_w_reg_dst),
        .ex_wb_reg_sel (ex_wb_reg_sel),
        .ex_w_hilo_ena (ex_w_hilo_ena),
        .ex_hi_res     (ex_hi_res),
        .ex_lo_res     (ex_lo_res),
        .ex_mem        (ex_mem.producer)
    );

    lsu u_lsu (
        .stall          (stall),
        .ex_alu_res     (ex_alu_res),
        .ex_rt_data     (ex_rt_data),
        .ex_ls_ena      (ex_ls_ena),
        .ex_ls_sel      (ex_ls_sel),
        .ex_mem         (ex_mem.consumer),
        .ram            (ram_bus.lsu_side),
        .mem_alu_res    (mem_alu_res),
        .mem_w_reg_ena  (mem_w_reg_ena),
        .mem_w_reg_dst  (mem_w_reg_dst),
        .mem_r_data     (mem_r_data),
        .mem_wb_reg_sel (mem_wb_reg_sel),
        .mem_w_hilo_ena (mem_w_hilo_ena),
        .mem_hi_res     (mem_hi_res),
        .mem_lo_res     (mem_lo_res)
    );

    data_ram u_data_ram (
        .clk (clk),
        .ram (ram_bus.ram_side)
    );

endmodule

`default_nettype wire

// File: verif/mem_stage_tb.sv
`default_nettype none

`include "mem_stage_macros.svh"

module mem_stage_tb;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int REF_BYTES      = 4 << `MEM_RAM_ADDR_W;
    localparam int PT_W           = 3*`MEM_DATA_W + 9;  // All pass-through outputs

    logic                   clk;
    logic                   reset;
    logic                   stall;
    logic [`MEM_DATA_W-1:0] ex_alu_res;
    logic [`MEM_DATA_W-1:0] ex_rt_data;
    logic                   ex_ls_ena;
    logic [3:0]             ex_ls_sel;
    logic                   ex_w_reg_ena;
    logic [4:0]             ex_w_reg_dst;
    logic                   ex_wb_reg_sel;
    logic [1:0]             ex_w_hilo_ena;
    logic [`MEM_DATA_W-1:0] ex_hi_res;
    logic [`MEM_DATA_W-1:0] ex_lo_res;

    logic [`MEM_DATA_W-1:0] mem_alu_res;
    logic                   mem_w_reg_ena;
    logic [4:0]             mem_w_reg_dst;
    logic [`MEM_DATA_W-1:0] mem_r_data;
    logic                   mem_wb_reg_sel;
    logic [1:0]             mem_w_hilo_ena;
    logic [`MEM_DATA_W-1:0] mem_hi_res;
    logic [`MEM_DATA_W-1:0] mem_lo_res;

    integer                 seed;
    int                     cycles = 0;
    int                     n_stall;
    logic [7:0]             ref_mem [0:REF_BYTES-1];    // Byte-addressed RAM mirror
    logic [PT_W-1:0]        nxt_pt;                     // Expected after the next edge
    logic [PT_W-1:0]        cur_pt;
    logic [`MEM_DATA_W-1:0] nxt_rd;
    logic [`MEM_DATA_W-1:0] cur_rd;
    logic [31:0]            addr;
    logic [31:0]            data;
    logic [31:0]            rt;

    mem_stage_top DUT (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .ex_alu_res     (ex_alu_res),
        .ex_rt_data     (ex_rt_data),
        .ex_ls_ena      (ex_ls_ena),
        .ex_ls_sel      (ex_ls_sel),
        .ex_w_reg_ena   (ex_w_reg_ena),
        .ex_w_reg_dst   (ex_w_reg_dst),
        .ex_wb_reg_sel  (ex_wb_reg_sel),
        .ex_w_hilo_ena  (ex_w_hilo_ena),
        .ex_hi_res      (ex_hi_res),
        .ex_lo_res      (ex_lo_res),
        .mem_alu_res    (mem_alu_res),
        .mem_w_reg_ena  (mem_w_reg_ena),
        .mem_w_reg_dst  (mem_w_reg_dst),
        .mem_r_data     (mem_r_data),
        .mem_wb_reg_sel (mem_wb_reg_sel),
        .mem_w_hilo_ena (mem_w_hilo_ena),
        .mem_hi_res     (mem_hi_res),
        .mem_lo_res     (mem_lo_res)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Simulation FAILED");
            $fatal(1, "Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    // ######################################
    // Reference model
    // ######################################

    always @(posedge clk) begin
        cur_pt <= nxt_pt;                               // Outputs lag the request by one edge
        cur_rd <= nxt_rd;
    end

    function automatic logic [31:0] expected_load(input logic [3:0] sel, input logic [31:0] a);
        logic [`MEM_RAM_ADDR_W+1:0] i;
        logic [7:0]                 b;
        logic [15:0]                h;
        i = a[`MEM_RAM_ADDR_W+1:0];
        b = ref_mem[i];
        h = {ref_mem[i+1], ref_mem[i]};
        case (sel)
            `LS_LB:  return {{24{b[7]}}, b};
            `LS_LBU: return {24'd0, b};
            `LS_LH:  return {{16{h[15]}}, h};
            `LS_LHU: return {16'd0, h};
            `LS_LW:  return {ref_mem[i+3], ref_mem[i+2], h};
            default: return 32'd0;
        endcase
    endfunction

    task automatic update_ref_mem(input logic [3:0] sel, input logic [31:0] a,
                                  input logic [31:0] d);
        logic [`MEM_RAM_ADDR_W+1:0] i;
        i = a[`MEM_RAM_ADDR_W+1:0];
        case (sel)
            `LS_SB: ref_mem[i] = d[7:0];
            `LS_SH: begin
                ref_mem[i]   = d[7:0];
                ref_mem[i+1] = d[15:8];
            end
            `LS_SW: begin
                for (int k = 0; k < 4; k++) begin
                    ref_mem[i+k] = d[k*8 +: 8];
                end
            end
            default: ;
        endcase
    endtask

    // ######################################
    // Stimulus
    // ######################################

    task automatic apply_request(input logic stl, input logic ls_en, input logic [3:0] sel,
                                 input logic [31:0] a, input logic [31:0] d);
        logic        w_ena;
        logic [4:0]  dst;
        logic        wbs;
        logic [1:0]  hilo;
        logic [31:0] hi;
        logic [31:0] lo;
        w_ena = $random(seed);
        dst   = $random(seed);
        wbs   = $random(seed);
        hilo  = $random(seed);
        hi    = $random(seed);
        lo    = $random(seed);
        @(posedge clk);
        stall         <= stl;
        ex_alu_res    <= a;
        ex_rt_data    <= d;
        ex_ls_ena     <= ls_en;
        ex_ls_sel     <= sel;
        ex_w_reg_ena  <= w_ena;
        ex_w_reg_dst  <= dst;
        ex_wb_reg_sel <= wbs;
        ex_w_hilo_ena <= hilo;
        ex_hi_res     <= hi;
        ex_lo_res     <= lo;
        if (!stl) begin                                 // Stalled requests leave no trace
            if (ls_en) begin
                update_ref_mem(sel, a, d);
            end
            nxt_pt <= {a, w_ena, dst, wbs, hilo, hi, lo};
            nxt_rd <= ls_en ? expected_load(sel, a) : 32'd0;
        end
    endtask

    task automatic mem_op(input logic [3:0] sel, input logic [31:0] a, input logic [31:0] d);
        apply_request(1'b0, 1'b1, sel, a, d);
    endtask

    task automatic alu_op();
        apply_request(1'b0, 1'b0, $random(seed), $random(seed), $random(seed));
    endtask

    // ######################################
    // Checkers
    // ######################################

    always @(negedge clk) begin
        if (!reset) begin
            assert (mem_r_data === cur_rd) else begin
                $display("** Error at %0t: mem_r_data is %h, expected %h",
                         $time, mem_r_data, cur_rd);
                $display("Simulation FAILED");
                $fatal(1, "Load data mismatch");
            end
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            assert ({mem_alu_res, mem_w_reg_ena, mem_w_reg_dst, mem_wb_reg_sel,
                     mem_w_hilo_ena, mem_hi_res, mem_lo_res} === cur_pt) else begin
                $display("** Error at %0t: pass-through fields are %h, expected %h", $time,
                         {mem_alu_res, mem_w_reg_ena, mem_w_reg_dst, mem_wb_reg_sel,
                          mem_w_hilo_ena, mem_hi_res, mem_lo_res}, cur_pt);
                $display("Simulation FAILED");
                $fatal(1, "Pass-through mismatch");
            end
        end
    end

    initial begin
        seed          = 32'h7b05_c53d;
        reset         = 1'b1;
        stall         = 1'b0;
        ex_alu_res    = '0;
        ex_rt_data    = '0;
        ex_ls_ena     = 1'b1;                           // Load and write-back pending in reset
        ex_ls_sel     = `LS_LW;
        ex_w_reg_ena  = 1'b1;
        ex_w_reg_dst  = '0;
        ex_wb_reg_sel = 1'b0;
        ex_w_hilo_ena = 2'b11;
        ex_hi_res     = '0;
        ex_lo_res     = '0;
        nxt_pt        = '0;
        nxt_rd        = '0;
        cur_pt        = '0;
        cur_rd        = '0;
        repeat (3) @(posedge clk);
        reset         <= 1'b0;
        ex_ls_ena     <= 1'b0;
        ex_ls_sel     <= `LS_SEL_NONE;
        ex_w_reg_ena  <= 1'b0;
        ex_w_hilo_ena <= 2'b00;
        @(negedge clk);
        assert (mem_w_reg_ena === 1'b0 && mem_w_hilo_ena === 2'b00 && mem_r_data === '0)
        else begin
            $display("** Error at %0t: write-back enables or load data not cleared by reset",
                     $time);
            $display("Simulation FAILED");
            $fatal(1, "Reset state mismatch");
        end

        repeat (60) begin                               // Word round trips
            addr      = $random(seed);
            addr[1:0] = 2'b00;
            data      = $random(seed);
            mem_op(`LS_SW, addr, data);
            mem_op(`LS_LW, addr, $random(seed));
        end

        repeat (8) begin                                // Byte lanes
            addr      = $random(seed);
            addr[1:0] = 2'b00;
            mem_op(`LS_SW, addr, $random(seed));
            for (int i = 0; i < 4; i++) begin
                rt    = $random(seed);
                rt[7] = i[0];                           // Both signs per word
                mem_op(`LS_SB, addr + i, rt);
            end
            for (int i = 0; i < 4; i++) begin
                mem_op(`LS_LB, addr + i, $random(seed));
                mem_op(`LS_LBU, addr + i, $random(seed));
            end
            mem_op(`LS_LW, addr, $random(seed));
        end

        repeat (8) begin                                // Halfword lanes
            addr      = $random(seed);
            addr[1:0] = 2'b00;
            mem_op(`LS_SW, addr, $random(seed));
            for (int i = 0; i < 2; i++) begin
                rt     = $random(seed);
                rt[15] = i[0];
                mem_op(`LS_SH, addr + 2*i, rt);
            end
            for (int i = 0; i < 2; i++) begin
                mem_op(`LS_LH, addr + 2*i, $random(seed));
                mem_op(`LS_LHU, addr + 2*i, $random(seed));
            end
            mem_op(`LS_LW, addr, $random(seed));
        end

        repeat (150) alu_op();

        repeat (10) begin                               // Stall
            addr      = $random(seed);
            addr[1:0] = 2'b00;
            mem_op(`LS_SW, addr, $random(seed));
            rt      = $random(seed);
            n_stall = 1 + {$random(seed)} % 4;
            apply_request(1'b1, 1'b1, `LS_SW, addr, rt);
            repeat (n_stall) begin
                apply_request(1'b1, $random(seed), $random(seed), $random(seed),
                              $random(seed));
            end
            mem_op(`LS_LW, addr, $random(seed));        // Still the old word
            mem_op(`LS_SW, addr, rt);
            mem_op(`LS_LW, addr, $random(seed));
        end

        alu_op();
        alu_op();
        repeat (2) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_stage.f
+incdir+common
common/mem_stage_pkg.sv
common/data_ram_if.sv
common/ex_mem_if.sv
hdl/ex_mem_reg.sv
hdl/data_ram.sv
lsu/lsu.sv
hdl/mem_stage_top.sv
verif/mem_stage_tb.sv

// File: Bender.yml
package:
  name: mem_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mem_stage_pkg.sv
      - common/data_ram_if.sv
      - common/ex_mem_if.sv
      - hdl/ex_mem_reg.sv
      - hdl/data_ram.sv
      - lsu/lsu.sv
      - hdl/mem_stage_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/mem_stage_tb.sv
